// File: verilog/crdma_pkg.sv
package crdma_pkg;

    // Address space walked by both source and destination walkers
    localparam int AW = 16;

    typedef logic [AW-1:0] addr_t;
    typedef logic [3:0]    engine_id_t;

    // One word of the instruction stream as it arrives on inst_m
    typedef struct packed {
        engine_id_t  id;
        logic        first;
        logic [10:0] rsvd;
        logic [15:0] payload;
    } inst_word_t;

    localparam int DESC_WORDS = 4;

    // Word 0 fills the top 16 bits and word 3 the bottom 16
    // Sizes hold the element count minus one, steps are unsigned
    typedef struct packed {
        addr_t      src_base;
        logic [3:0] dim0_size;
        logic [3:0] dim1_size;
        logic [3:0] src_dim0_step;
        logic [3:0] src_dim1_step;
        addr_t      dst_base;
        logic [3:0] dst_dim0_step;
        logic [3:0] dst_dim1_step;
        logic [7:0] rsvd;
    } desc_t;

    // Walker output, last marks the final element of the descriptor
    typedef struct packed {
        addr_t addr;
        logic  last;
    } walk_t;

    // One transfer command as seen by the memory port
    typedef struct packed {
        addr_t src;
        addr_t dst;
        logic  last;
    } cmd_t;

    // Credits granted by the command receiver after reset
    localparam int CMD_CREDITS = 4;

    // Wide enough to hold CMD_CREDITS
    localparam int CREDIT_W = 3;

endpackage

// File: verilog/frs.sv
module frs #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t m_data,
    input  logic     m_valid,
    output logic     m_ready,
    output payload_t s_data,
    output logic     s_valid,
    input  logic     s_ready
);

    logic     skid_valid;
    payload_t skid_data;
    logic     load_out;
    logic     m_fire;

    // The skid entry catches the item that arrives while the output stalls
    assign m_ready  = !skid_valid;
    assign m_fire   = m_valid && m_ready;
    assign load_out = !s_valid || s_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            s_valid    <= skid_valid || m_valid;
            skid_valid <= 1'b0;
        end else if (m_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            // Oldest item first, the skid entry was accepted earlier
            if (skid_valid) begin
                s_data <= skid_data;
            end else begin
                s_data <= m_data;
            end
        end else if (m_fire) begin
            skid_data <= m_data;
        end
    end

endmodule

// File: verilog/inst_parse.sv
module inst_parse #(
    parameter crdma_pkg::engine_id_t engine_id = 4'h0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  crdma_pkg::inst_word_t inst_m_data,
    input  logic                  inst_m_valid,
    output logic                  inst_m_ready,
    output crdma_pkg::inst_word_t fwd_data,
    output logic                  fwd_valid,
    input  logic                  fwd_ready,
    output crdma_pkg::desc_t      start_data,
    output logic                  start_valid,
    input  logic                  start_ready
);
    import crdma_pkg::*;

    localparam int CNT_W   = $clog2(DESC_WORDS);
    localparam int DESC_W  = $bits(desc_t);
    localparam int SLICE_W = DESC_W / DESC_WORDS;

    logic [CNT_W-1:0] cnt;
    logic             own;
    logic             accept;
    logic             own_take;
    logic             fwd_take;
    logic             last_word;
    logic             desc_wait;
    logic             fwd_full;

    assign own       = inst_m_data.id == engine_id;
    assign desc_wait = start_valid && !start_ready;
    assign fwd_full  = fwd_valid && !fwd_ready;

    assign inst_m_ready = !desc_wait && !fwd_full;
    assign accept       = inst_m_valid && inst_m_ready;
    assign own_take     = accept && own;
    assign fwd_take     = accept && !own;

    // cnt counts own words gathered so far, zero means no descriptor is open
    assign last_word = own_take && !inst_m_data.first && (cnt == CNT_W'(DESC_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt         <= '0;
            start_valid <= 1'b0;
            fwd_valid   <= 1'b0;
        end else begin
            if (own_take) begin
                if (inst_m_data.first) begin
                    cnt <= CNT_W'(1);
                end else if (last_word) begin
                    cnt <= '0;
                end else if (cnt != '0) begin
                    cnt <= cnt + 1'b1;
                end
            end

            if (last_word) begin
                start_valid <= 1'b1;
            end else if (start_ready) begin
                start_valid <= 1'b0;
            end

            if (fwd_take) begin
                fwd_valid <= 1'b1;
            end else if (fwd_ready) begin
                fwd_valid <= 1'b0;
            end
        end
    end

    // Payloads shift in at the bottom so word 0 ends up in src_base
    always_ff @(posedge clk) begin
        if (own_take) begin
            start_data <= desc_t'({start_data[DESC_W-SLICE_W-1:0], inst_m_data.payload});
        end
        if (fwd_take) begin
            fwd_data <= inst_m_data;
        end
    end

endmodule

// File: verilog/dma_dim2.sv
module dma_dim2 (
    input  logic             clk,
    input  logic             rst_n,
    input  crdma_pkg::addr_t base,
    input  logic [3:0]       dim0_size,
    input  logic [3:0]       dim1_size,
    input  logic [3:0]       dim0_step,
    input  logic [3:0]       dim1_step,
    input  logic             start_fire,
    output logic             idle,
    output crdma_pkg::walk_t walk_data,
    output logic             walk_valid,
    input  logic             walk_ready
);
    import crdma_pkg::*;

    logic [3:0] size0_q;
    logic [3:0] size1_q;
    logic [3:0] step0_q;
    logic [3:0] step1_q;
    logic [3:0] i_q;
    logic [3:0] j_q;
    addr_t      addr_q;
    addr_t      row_q;
    logic       row_end;
    logic       last_elem;
    logic       advance;

    assign row_end   = i_q == size0_q;
    assign last_elem = row_end && (j_q == size1_q);
    assign advance   = walk_valid && walk_ready;

    // The walker is busy exactly while an address is on offer
    assign idle      = !walk_valid;
    assign walk_data = '{addr: addr_q, last: last_elem};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            walk_valid <= 1'b0;
            i_q        <= '0;
            j_q        <= '0;
        end else if (start_fire) begin
            walk_valid <= 1'b1;
            i_q        <= '0;
            j_q        <= '0;
        end else if (advance) begin
            if (last_elem) begin
                walk_valid <= 1'b0;
            end else if (row_end) begin
                i_q <= '0;
                j_q <= j_q + 1'b1;
            end else begin
                i_q <= i_q + 1'b1;
            end
        end
    end

    // row_q holds base + j*dim1_step, the inner walk adds dim0_step to it
    // Sums wrap in addr_t on purpose
    always_ff @(posedge clk) begin
        if (start_fire) begin
            size0_q <= dim0_size;
            size1_q <= dim1_size;
            step0_q <= dim0_step;
            step1_q <= dim1_step;
            addr_q  <= base;
            row_q   <= base;
        end else if (advance && !last_elem) begin
            if (row_end) begin
                row_q  <= row_q + addr_t'(step1_q);
                addr_q <= row_q + addr_t'(step1_q);
            end else begin
                addr_q <= addr_q + addr_t'(step0_q);
            end
        end
    end

endmodule

// File: verilog/xfer_join.sv
module xfer_join (
    input  logic             clk,
    input  logic             rst_n,
    input  crdma_pkg::walk_t src_data,
    input  logic             src_valid,
    output logic             src_ready,
    input  crdma_pkg::walk_t dst_data,
    input  logic             dst_valid,
    output logic             dst_ready,
    output crdma_pkg::cmd_t  cmd_data,
    output logic             cmd_valid,
    input  logic             cmd_credit
);
    import crdma_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                have_credit;
    logic                take;

    // A command sitting on cmd_valid is charged at the next edge,
    // so it already holds one of the credits counted here
    assign have_credit = cmd_valid ? (credits > CREDIT_W'(1)) : (credits != '0);

    // Both walkers advance together, which keeps the pairs aligned
    assign take      = src_valid && dst_valid && have_credit;
    assign src_ready = take;
    assign dst_ready = take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
            credits   <= CREDIT_W'(CMD_CREDITS);
        end else begin
            cmd_valid <= take;
            case ({cmd_credit, cmd_valid})
                2'b10: begin
                    credits <= credits + 1'b1;
                end
                2'b01: begin
                    credits <= credits - 1'b1;
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

    // Both walkers share the element counts, so the source last flag stands
    // for the pair
    always_ff @(posedge clk) begin
        if (take) begin
            cmd_data <= '{src: src_data.addr, dst: dst_data.addr, last: src_data.last};
        end
    end

endmodule

// File: verilog/crdma.sv
module crdma #(
    parameter crdma_pkg::engine_id_t engine_id = 4'h0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  crdma_pkg::inst_word_t inst_m_data,
    input  logic                  inst_m_valid,
    output logic                  inst_m_ready,
    output crdma_pkg::inst_word_t inst_s_data,
    output logic                  inst_s_valid,
    input  logic                  inst_s_ready,
    output crdma_pkg::cmd_t       cmd_data,
    output logic                  cmd_valid,
    input  logic                  cmd_credit
);
    import crdma_pkg::*;

    desc_t      start_data;
    logic       start_valid;
    logic       start_ready;
    desc_t      desc_data;
    logic       desc_valid;
    logic       desc_ready;
    logic       start_fire;
    inst_word_t fwd_data;
    logic       fwd_valid;
    logic       fwd_ready;
    walk_t      src_walk_data;
    logic       src_walk_valid;
    logic       src_walk_ready;
    logic       src_idle;
    walk_t      dst_walk_data;
    logic       dst_walk_valid;
    logic       dst_walk_ready;
    logic       dst_idle;

    // A descriptor launches only once both walkers have finished the last one
    assign desc_ready = src_idle && dst_idle;
    assign start_fire = desc_valid && desc_ready;

    inst_parse #(.engine_id(engine_id)) i_inst_parse (
        .clk(clk),
        .rst_n(rst_n),
        .inst_m_data(inst_m_data),
        .inst_m_valid(inst_m_valid),
        .inst_m_ready(inst_m_ready),
        .fwd_data(fwd_data),
        .fwd_valid(fwd_valid),
        .fwd_ready(fwd_ready),
        .start_data(start_data),
        .start_valid(start_valid),
        .start_ready(start_ready)
    );

    frs #(.payload_t(desc_t)) i_frs_desc (
        .clk(clk),
        .rst_n(rst_n),
        .m_data(start_data),
        .m_valid(start_valid),
        .m_ready(start_ready),
        .s_data(desc_data),
        .s_valid(desc_valid),
        .s_ready(desc_ready)
    );

    frs #(.payload_t(inst_word_t)) i_frs_fwd (
        .clk(clk),
        .rst_n(rst_n),
        .m_data(fwd_data),
        .m_valid(fwd_valid),
        .m_ready(fwd_ready),
        .s_data(inst_s_data),
        .s_valid(inst_s_valid),
        .s_ready(inst_s_ready)
    );

    dma_dim2 src_walk (
        .clk(clk),
        .rst_n(rst_n),
        .base(desc_data.src_base),
        .dim0_size(desc_data.dim0_size),
        .dim1_size(desc_data.dim1_size),
        .dim0_step(desc_data.src_dim0_step),
        .dim1_step(desc_data.src_dim1_step),
        .start_fire(start_fire),
        .idle(src_idle),
        .walk_data(src_walk_data),
        .walk_valid(src_walk_valid),
        .walk_ready(src_walk_ready)
    );

    dma_dim2 dst_walk (
        .clk(clk),
        .rst_n(rst_n),
        .base(desc_data.dst_base),
        .dim0_size(desc_data.dim0_size),
        .dim1_size(desc_data.dim1_size),
        .dim0_step(desc_data.dst_dim0_step),
        .dim1_step(desc_data.dst_dim1_step),
        .start_fire(start_fire),
        .idle(dst_idle),
        .walk_data(dst_walk_data),
        .walk_valid(dst_walk_valid),
        .walk_ready(dst_walk_ready)
    );

    xfer_join i_xfer_join (
        .clk(clk),
        .rst_n(rst_n),
        .src_data(src_walk_data),
        .src_valid(src_walk_valid),
        .src_ready(src_walk_ready),
        .dst_data(dst_walk_data),
        .dst_valid(dst_walk_valid),
        .dst_ready(dst_walk_ready),
        .cmd_data(cmd_data),
        .cmd_valid(cmd_valid),
        .cmd_credit(cmd_credit)
    );

endmodule

// File: testbench/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset is held through the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: testbench/crdma_asserts.sv
module crdma_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input crdma_pkg::walk_t               src_data,
    input crdma_pkg::walk_t               dst_data,
    input logic                           take,
    input logic                           cmd_valid,
    input logic [crdma_pkg::CREDIT_W-1:0] credits
);
    timeunit 1ns;
    timeprecision 1ps;
    import crdma_pkg::*;

    // Both walkers share the element counts, so an accepted pair ends together
    last_flags_match: assert property (
        @(posedge clk) disable iff (!rst_n) take |-> (src_data.last == dst_data.last)
    ) else $error("source and destination last flags differ on an accepted pair");

    send_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_valid |-> (credits != '0)
    ) else $error("cmd_valid is high while the credit count is zero");

    credit_ceiling: assert property (
        @(posedge clk) disable iff (!rst_n) credits <= CREDIT_W'(CMD_CREDITS)
    ) else $error("credit count is above the number granted at reset");

endmodule

bind xfer_join crdma_asserts i_crdma_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .src_data(src_data),
    .dst_data(dst_data),
    .take(src_ready),
    .cmd_valid(cmd_valid),
    .credits(credits)
);

// File: testbench/crdma_tb.sv
module crdma_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import crdma_pkg::*;

    localparam engine_id_t ENGINE_ID = 4'd5;
    localparam int NUM_ENTRIES = 10;

    typedef enum logic [1:0] {WORD_ONLY, DESC_ONLY, DESC_SPLIT} entry_kind_t;

    // A split entry sends its foreign word between descriptor words 1 and 2
    typedef struct packed {
        entry_kind_t kind;
        desc_t       desc;
        inst_word_t  word;
    } entry_t;

    logic       clk;
    logic       rst_n;
    inst_word_t inst_m_data;
    logic       inst_m_valid;
    logic       inst_m_ready;
    inst_word_t inst_s_data;
    logic       inst_s_valid;
    logic       inst_s_ready;
    cmd_t       cmd_data;
    logic       cmd_valid;
    logic       cmd_credit;

    entry_t     stim_table [NUM_ENTRIES];
    cmd_t       exp_cmds [$];
    inst_word_t exp_words [$];
    int         cmds_seen = 0;
    int         outstanding = 0;
    int         limit_cycles = 0;
    logic       verdict_given = 1'b0;

    clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    crdma #(.engine_id(ENGINE_ID)) crdma_i (
        .clk(clk),
        .rst_n(rst_n),
        .inst_m_data(inst_m_data),
        .inst_m_valid(inst_m_valid),
        .inst_m_ready(inst_m_ready),
        .inst_s_data(inst_s_data),
        .inst_s_valid(inst_s_valid),
        .inst_s_ready(inst_s_ready),
        .cmd_data(cmd_data),
        .cmd_valid(cmd_valid),
        .cmd_credit(cmd_credit)
    );

    task automatic stop_run();
        verdict_given = 1'b1;
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_cmd(input cmd_t actual, input cmd_t expected);
        if (actual !== expected) begin
            $display("FAILED cmd_data: got %h, expected %h", actual, expected);
            stop_run();
        end
    endtask

    task automatic compare_word(input inst_word_t actual, input inst_word_t expected);
        if (actual !== expected) begin
            $display("FAILED inst_s_data: got %h, expected %h", actual, expected);
            stop_run();
        end
    endtask

    function automatic desc_t pack_desc(input addr_t src_base, input logic [3:0] size0,
                                        input logic [3:0] size1, input logic [3:0] src0,
                                        input logic [3:0] src1, input addr_t dst_base,
                                        input logic [3:0] dst0, input logic [3:0] dst1);
        return '{src_base, size0, size1, src0, src1, dst_base, dst0, dst1, 8'h3c};
    endfunction

    function automatic inst_word_t foreign_word(input engine_id_t id, input logic [15:0] payload);
        return '{id, payload[0], 11'h5a3, payload};
    endfunction

    // Each element maps to base + j*dim1_step + i*dim0_step with i running fastest
    // and the sum taken modulo 2**16
    function automatic void expand_desc(input desc_t d);
        cmd_t c;
        for (int j = 0; j <= int'(d.dim1_size); j++) begin
            for (int i = 0; i <= int'(d.dim0_size); i++) begin
                c.src  = d.src_base + addr_t'(j * d.src_dim1_step + i * d.src_dim0_step);
                c.dst  = d.dst_base + addr_t'(j * d.dst_dim1_step + i * d.dst_dim0_step);
                c.last = (i == int'(d.dim0_size)) && (j == int'(d.dim1_size));
                exp_cmds.push_back(c);
            end
        end
    endfunction

    // The task starts just after a rising edge and returns at the edge that moved the word
    task automatic send_word(input inst_word_t w);
        inst_m_data  <= w;
        inst_m_valid <= 1'b1;
        @(negedge clk);
        while (!inst_m_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_entry(input entry_t e);
        inst_word_t w;
        if (e.kind == WORD_ONLY) begin
            exp_words.push_back(e.word);
            send_word(e.word);
        end else begin
            expand_desc(e.desc);
            for (int k = 0; k < DESC_WORDS; k++) begin
                w = '{ENGINE_ID, k == 0, 11'h000, e.desc[$bits(desc_t) - 1 - 16 * k -: 16]};
                send_word(w);
                if (e.kind == DESC_SPLIT && k == 1) begin
                    exp_words.push_back(e.word);
                    send_word(e.word);
                end
            end
        end
    endtask

    initial begin : run_table
        int total_cmds;
        inst_m_valid = 1'b0;
        inst_m_data  = '0;
        stim_table[0] = '{DESC_ONLY, pack_desc(16'h1000, 4'd0, 4'd0, 4'h3, 4'h7,
                                               16'h2000, 4'h1, 4'h2), '0};
        stim_table[1] = '{WORD_ONLY, '0, foreign_word(4'h3, 16'hbeef)};
        stim_table[2] = '{DESC_ONLY, pack_desc(16'hfff8, 4'd2, 4'd1, 4'h4, 4'h9,
                                               16'h0100, 4'h2, 4'hf), '0};
        stim_table[3] = '{DESC_SPLIT, pack_desc(16'hfffe, 4'd3, 4'd3, 4'h1, 4'hf,
                                                16'h7ff0, 4'h8, 4'h3),
                          foreign_word(4'ha, 16'h1234)};
        stim_table[4] = '{WORD_ONLY, '0, foreign_word(4'h0, 16'h0005)};
        stim_table[5] = '{DESC_ONLY, pack_desc(16'h8000, 4'd15, 4'd1, 4'hf, 4'h1,
                                               16'hffc0, 4'h8, 4'h0), '0};
        stim_table[6] = '{DESC_ONLY, pack_desc(16'h0040, 4'd0, 4'd4, 4'h0, 4'hc,
                                               16'hffff, 4'h0, 4'h5), '0};
        stim_table[7] = '{DESC_SPLIT, pack_desc(16'h3333, 4'd4, 4'd2, 4'h2, 4'hb,
                                                16'hfff0, 4'h6, 4'hd),
                          foreign_word(4'hf, 16'hcafe)};
        stim_table[8] = '{WORD_ONLY, '0, foreign_word(4'h6, 16'h5555)};
        stim_table[9] = '{DESC_ONLY, pack_desc(16'hff00, 4'd1, 4'd15, 4'h9, 4'hf,
                                               16'hfe00, 4'hf, 4'h0), '0};
        total_cmds = 0;
        foreach (stim_table[n]) begin
            if (stim_table[n].kind != WORD_ONLY) begin
                total_cmds += (int'(stim_table[n].desc.dim0_size) + 1)
                            * (int'(stim_table[n].desc.dim1_size) + 1);
            end
        end
        limit_cycles = 40 * NUM_ENTRIES + 20 * total_cmds;

        wait (rst_n === 1'b1);
        repeat (3) begin
            @(negedge clk);
            if (cmd_valid !== 1'b0 || inst_s_valid !== 1'b0) begin
                $display("cmd_valid or inst_s_valid was not low right after reset");
                stop_run();
            end
        end

        @(posedge clk);
        foreach (stim_table[n]) begin
            send_entry(stim_table[n]);
        end
        inst_m_valid <= 1'b0;

        while (exp_cmds.size() != 0 || exp_words.size() != 0 || outstanding != 0) begin
            @(negedge clk);
        end
        // Extra cycles catch duplicated commands or words
        repeat (30) @(negedge clk);
        verdict_given = 1'b1;
        if (exp_cmds.size() == 0 && exp_words.size() == 0 && outstanding == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("Expected outputs or credits were still pending at the end");
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Command receiver and pass-through sink with random credit delays and stalls
    initial begin : drive_sinks
        int unsigned wait_left;
        int unsigned hold_left;
        int          credits_returned;
        void'($urandom(32'h83a0));
        cmd_credit   = 1'b0;
        inst_s_ready = 1'b0;
        wait_left        = 0;
        hold_left        = 60;
        credits_returned = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            inst_s_ready <= ($urandom % 4) != 0;
            cmd_credit   <= 1'b0;
            if (hold_left != 0) begin
                hold_left--;
            end else if (wait_left != 0) begin
                wait_left--;
            end else if (cmds_seen > credits_returned) begin
                cmd_credit <= 1'b1;
                credits_returned++;
                wait_left = $urandom % 7;
                if ($urandom % 8 == 0) begin
                    hold_left = 20 + $urandom % 30;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (cmd_valid) begin
                cmds_seen++;
                outstanding++;
                if (exp_cmds.size() == 0) begin
                    $display("A command came out with no command left to expect");
                    stop_run();
                end else begin
                    compare_cmd(cmd_data, exp_cmds.pop_front());
                end
                if (outstanding > CMD_CREDITS) begin
                    $display("More than %0d commands are waiting for credits", CMD_CREDITS);
                    stop_run();
                end
            end
            if (cmd_credit) begin
                outstanding--;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1 && inst_s_valid && inst_s_ready) begin
            if (exp_words.size() == 0) begin
                $display("A word came out on inst_s with no foreign word left to expect");
                stop_run();
            end else begin
                compare_word(inst_s_data, exp_words.pop_front());
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("The run timed out after %0d cycles without finishing", limit_cycles);
        stop_run();
    end

    final begin
        if (!verdict_given) begin
            $display("The simulation stopped before the table was finished");
            $display("TESTBENCH FAILED");
        end
    end

endmodule

// File: sources.f
verilog/crdma_pkg.sv
verilog/frs.sv
verilog/inst_parse.sv
verilog/dma_dim2.sv
verilog/xfer_join.sv
verilog/crdma.sv
testbench/clk_gen.sv
testbench/crdma_asserts.sv
testbench/crdma_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = crdma_tb
FILELIST  = sources.f
LOG       = sim.log

.PHONY: sim clean

# The run fails when the log reports a failure or never reports a pass
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
